// ==== verilog/icache_consts.svh ====
`ifndef ICACHE_CONSTS_SVH
`define ICACHE_CONSTS_SVH

//////////////////////////////////////////////////////////////////////
// cache geometry
//////////////////////////////////////////////////////////////////////

// 8-byte blocks, set index taken from address bits 5..3
`define ICACHE_NUM_SETS 8
`define ICACHE_SET_BITS 3
`define ICACHE_NUM_WAYS 4

//////////////////////////////////////////////////////////////////////
// request queue and prefetch
//////////////////////////////////////////////////////////////////////

`define ICACHE_QUEUE_LEN 8
`define ICACHE_PTR_BITS 3

// sequential blocks fetched beyond the demand block
`define ICACHE_NUM_PREFETCH 2

`endif

// ==== verilog/icache_pkg.sv ====
`default_nettype none

`include "icache_consts.svh"

package icache_pkg;

  // byte address and one instruction block
  typedef logic [31:0] addr_t;
  typedef logic [63:0] block_t;

  // address split, bits 5..3 pick the set and 31..6 form the tag
  typedef logic [`ICACHE_SET_BITS-1:0] set_idx_t;
  typedef logic [25:0] cache_tag_t;

  // bus transaction tag, zero means no transaction
  typedef logic [3:0] mem_tag_t;

  typedef logic [1:0] way_t;

  typedef enum logic [1:0] {
    BUS_NONE = 2'h0,
    BUS_LOAD = 2'h1
  } bus_command_t;

endpackage

`default_nettype wire

// ==== verilog/fetch_addr_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "icache_consts.svh"

module fetch_addr_gen (
  input  wire logic                                    clock,
  input  wire logic                                    reset,
  input  wire icache_pkg::addr_t                       fetch_addr,
  output logic                                         addr_changed,
  output icache_pkg::addr_t                            demand_block,
  output icache_pkg::addr_t [`ICACHE_NUM_PREFETCH-1:0] prefetch_blocks
);

  icache_pkg::addr_t last_addr;

  // all ones after reset so the first real address counts as new
  always_ff @(posedge clock) begin
    if (reset) begin
      last_addr <= '1;
    end else begin
      last_addr <= fetch_addr;
    end
  end

  always_comb begin
    addr_changed = (fetch_addr != last_addr);
  end

  // block aligned, 8 bytes per block
  always_comb begin
    demand_block = {fetch_addr[31:3], 3'b000};
  end

  for (genvar i = 0; i < `ICACHE_NUM_PREFETCH; i++) begin : g_prefetch
    always_comb begin
      prefetch_blocks[i] = demand_block + icache_pkg::addr_t'(8 * (i + 1));
    end
  end

endmodule

`default_nettype wire

// ==== verilog/cache_array.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "icache_consts.svh"

module cache_array (
  input  wire logic                     clock,
  input  wire logic                     reset,
  input  wire icache_pkg::addr_t  [2:0] rd_block,
  output logic                    [2:0] rd_hit,
  output icache_pkg::block_t      [2:0] rd_data,
  input  wire logic                     fill_en,
  input  wire icache_pkg::addr_t        fill_block_addr,
  input  wire icache_pkg::block_t       fill_data
);

  localparam int NUM_RD = 3;

  logic                   line_valid [`ICACHE_NUM_SETS][`ICACHE_NUM_WAYS];
  icache_pkg::cache_tag_t line_tag   [`ICACHE_NUM_SETS][`ICACHE_NUM_WAYS];
  icache_pkg::block_t     line_data  [`ICACHE_NUM_SETS][`ICACHE_NUM_WAYS];
  icache_pkg::way_t       fill_ptr   [`ICACHE_NUM_SETS];

  icache_pkg::set_idx_t   rd_set [NUM_RD];
  icache_pkg::cache_tag_t rd_tag [NUM_RD];
  icache_pkg::set_idx_t   fill_set;
  icache_pkg::cache_tag_t fill_tag;
  logic                   fill_present;
  icache_pkg::way_t       fill_hit_way;
  icache_pkg::way_t       fill_way;

  for (genvar p = 0; p < NUM_RD; p++) begin : g_rd_split
    assign rd_set[p] = rd_block[p][`ICACHE_SET_BITS+2:3];
    assign rd_tag[p] = rd_block[p][31:`ICACHE_SET_BITS+3];
  end

  //////////////////////////////////////////////////////////////////////
  // read ports
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    for (int p = 0; p < NUM_RD; p++) begin
      rd_hit[p]  = 1'b0;
      rd_data[p] = '0;
      for (int w = 0; w < `ICACHE_NUM_WAYS; w++) begin
        if (line_valid[rd_set[p]][w] && (line_tag[rd_set[p]][w] == rd_tag[p])) begin
          rd_hit[p]  = 1'b1;
          rd_data[p] = line_data[rd_set[p]][w];
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // fill port
  //////////////////////////////////////////////////////////////////////

  assign fill_set = fill_block_addr[`ICACHE_SET_BITS+2:3];
  assign fill_tag = fill_block_addr[31:`ICACHE_SET_BITS+3];

  // a block already present is rewritten in place
  always_comb begin
    fill_present = 1'b0;
    fill_hit_way = '0;
    for (int w = 0; w < `ICACHE_NUM_WAYS; w++) begin
      if (line_valid[fill_set][w] && (line_tag[fill_set][w] == fill_tag)) begin
        fill_present = 1'b1;
        fill_hit_way = icache_pkg::way_t'(w);
      end
    end
    fill_way = fill_present ? fill_hit_way : fill_ptr[fill_set];
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int s = 0; s < `ICACHE_NUM_SETS; s++) begin
        fill_ptr[s] <= '0;
        for (int w = 0; w < `ICACHE_NUM_WAYS; w++) begin
          line_valid[s][w] <= 1'b0;
        end
      end
    end else if (fill_en) begin
      line_valid[fill_set][fill_way] <= 1'b1;
      // oldest fill goes next
      if (!fill_present) begin
        if (fill_ptr[fill_set] == icache_pkg::way_t'(`ICACHE_NUM_WAYS - 1)) begin
          fill_ptr[fill_set] <= '0;
        end else begin
          fill_ptr[fill_set] <= fill_ptr[fill_set] + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    if (fill_en) begin
      line_tag[fill_set][fill_way]  <= fill_tag;
      line_data[fill_set][fill_way] <= fill_data;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/miss_queue.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "icache_consts.svh"

module miss_queue (
  input  wire logic                                    clock,
  input  wire logic                                    reset,
  input  wire logic                                    addr_changed,
  input  wire icache_pkg::addr_t                       demand_block,
  input  wire icache_pkg::addr_t [`ICACHE_NUM_PREFETCH-1:0] prefetch_blocks,
  input  wire logic [2:0]                              rd_hit,
  output icache_pkg::addr_t                            head_block,
  output icache_pkg::addr_t                            send_block,
  output icache_pkg::addr_t                            wait_block,
  output logic                                         send_req,
  input  wire logic                                    accepted,
  input  wire icache_pkg::mem_tag_t                    accepted_tag,
  input  wire logic                                    fill_done,
  output icache_pkg::mem_tag_t                         wait_tag
);

  localparam int NUM_CAND = `ICACHE_NUM_PREFETCH + 1;

  icache_pkg::addr_t    q_addr    [`ICACHE_QUEUE_LEN];
  logic                 q_valid   [`ICACHE_QUEUE_LEN];
  icache_pkg::mem_tag_t q_tag     [`ICACHE_QUEUE_LEN];
  icache_pkg::addr_t    q_addr_n  [`ICACHE_QUEUE_LEN];
  logic                 q_valid_n [`ICACHE_QUEUE_LEN];
  icache_pkg::mem_tag_t q_tag_n   [`ICACHE_QUEUE_LEN];

  // one extra bit so a full queue is representable
  logic [`ICACHE_PTR_BITS:0]   tail, send_ptr, wait_ptr;
  logic [`ICACHE_PTR_BITS:0]   tail_n, send_n, wait_n;
  logic [`ICACHE_PTR_BITS-1:0] send_idx, wait_idx;
  logic                        send_req_n;

  icache_pkg::addr_t cand_addr    [NUM_CAND];
  logic              cand_want    [NUM_CAND];
  logic              cand_pending [NUM_CAND];
  logic              head_busy;
  logic              retire;

  assign send_idx = send_ptr[`ICACHE_PTR_BITS-1:0];
  assign wait_idx = wait_ptr[`ICACHE_PTR_BITS-1:0];

  assign head_block = q_addr[0];
  assign send_block = q_addr[send_idx];
  assign wait_block = q_addr[wait_idx];
  assign wait_tag   = (wait_ptr < send_ptr) ? q_tag[wait_idx] : '0;

  //////////////////////////////////////////////////////////////////////
  // candidates and content match
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    cand_addr[0] = demand_block;
    cand_want[0] = !rd_hit[0];
    for (int c = 1; c < NUM_CAND; c++) begin
      cand_addr[c] = prefetch_blocks[c-1];
      cand_want[c] = 1'b1;
    end
    for (int c = 0; c < NUM_CAND; c++) begin
      cand_pending[c] = 1'b0;
      for (int i = 0; i < `ICACHE_QUEUE_LEN; i++) begin
        if (q_valid[i] && (q_addr[i] == cand_addr[c])) begin
          cand_pending[c] = 1'b1;
        end
      end
    end
  end

  // head still owed by memory, or out on the bus right now
  assign head_busy = (send_req && (send_ptr == '0)) ||
                     ((wait_ptr == '0) && (send_ptr != '0) && (q_tag[0] != '0));
  assign retire    = q_valid[0] && rd_hit[1] && !head_busy;

  //////////////////////////////////////////////////////////////////////
  // next state
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    q_addr_n  = q_addr;
    q_valid_n = q_valid;
    q_tag_n   = q_tag;
    tail_n    = tail;
    send_n    = send_ptr;
    wait_n    = wait_ptr;

    if (fill_done) begin
      wait_n = wait_n + 1'b1;
    end
    // skipped entries carry no tag, step past them
    for (int i = 0; i < `ICACHE_QUEUE_LEN; i++) begin
      if ((wait_n < send_ptr) && (q_tag[wait_n[`ICACHE_PTR_BITS-1:0]] == '0)) begin
        wait_n = wait_n + 1'b1;
      end
    end

    if (send_req) begin
      if (accepted) begin
        q_tag_n[send_idx] = accepted_tag;
        send_n            = send_n + 1'b1;
      end
    end else if ((send_ptr < tail) && rd_hit[2]) begin
      send_n = send_n + 1'b1;
    end

    if (retire) begin
      for (int i = 0; i < `ICACHE_QUEUE_LEN - 1; i++) begin
        q_addr_n[i]  = q_addr_n[i+1];
        q_valid_n[i] = q_valid_n[i+1];
        q_tag_n[i]   = q_tag_n[i+1];
      end
      q_addr_n[`ICACHE_QUEUE_LEN-1]  = '0;
      q_valid_n[`ICACHE_QUEUE_LEN-1] = 1'b0;
      q_tag_n[`ICACHE_QUEUE_LEN-1]   = '0;
      tail_n = tail_n - 1'b1;
      if (send_n != '0) begin
        send_n = send_n - 1'b1;
      end
      if (wait_n != '0) begin
        wait_n = wait_n - 1'b1;
      end
    end

    // demand first, then prefetch; dropped once full
    if (addr_changed) begin
      for (int c = 0; c < NUM_CAND; c++) begin
        if (cand_want[c] && !cand_pending[c] && (tail_n < `ICACHE_QUEUE_LEN)) begin
          q_addr_n[tail_n[`ICACHE_PTR_BITS-1:0]]  = cand_addr[c];
          q_valid_n[tail_n[`ICACHE_PTR_BITS-1:0]] = 1'b1;
          q_tag_n[tail_n[`ICACHE_PTR_BITS-1:0]]   = '0;
          tail_n = tail_n + 1'b1;
        end
      end
    end
  end

  // refused request stays up on the same entry
  assign send_req_n = send_req ? !accepted : ((send_ptr < tail) && !rd_hit[2]);

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < `ICACHE_QUEUE_LEN; i++) begin
        q_valid[i] <= 1'b0;
      end
      tail     <= '0;
      send_ptr <= '0;
      wait_ptr <= '0;
      send_req <= 1'b0;
    end else begin
      q_valid  <= q_valid_n;
      tail     <= tail_n;
      send_ptr <= send_n;
      wait_ptr <= wait_n;
      send_req <= send_req_n;
    end
  end

  always_ff @(posedge clock) begin
    q_addr <= q_addr_n;
    q_tag  <= q_tag_n;
  end

endmodule

`default_nettype wire

// ==== verilog/mem_bus_port.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_bus_port (
  input  wire logic                    clock,
  input  wire logic                    reset,
  input  wire logic                    send_req,
  input  wire icache_pkg::addr_t       send_block,
  input  wire icache_pkg::addr_t       wait_block,
  input  wire icache_pkg::mem_tag_t    wait_tag,
  input  wire icache_pkg::mem_tag_t    mem_response,
  input  wire icache_pkg::block_t      mem_data,
  input  wire icache_pkg::mem_tag_t    mem_tag,
  output icache_pkg::bus_command_t     mem_command,
  output icache_pkg::addr_t            mem_addr,
  output logic                         accepted,
  output icache_pkg::mem_tag_t         accepted_tag,
  output logic                         fill_done,
  output logic                         fill_en,
  output icache_pkg::addr_t            fill_block_addr,
  output icache_pkg::block_t           fill_data
);

  // command goes out in the send_req cycle, answered the same cycle
  always_comb begin
    mem_command  = send_req ? icache_pkg::BUS_LOAD : icache_pkg::BUS_NONE;
    mem_addr     = send_req ? send_block : '0;
    accepted     = send_req && (mem_response != '0);
    accepted_tag = mem_response;
  end

  // returns come back in order, so only the oldest tag can match
  always_comb begin
    fill_done = (wait_tag != '0) && (mem_tag == wait_tag);
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      fill_en <= 1'b0;
    end else begin
      fill_en <= fill_done;
    end
  end

  always_ff @(posedge clock) begin
    fill_block_addr <= wait_block;
    fill_data       <= mem_data;
  end

endmodule

`default_nettype wire

// ==== verilog/icache.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "icache_consts.svh"

module icache (
  input  wire logic                 clock,
  input  wire logic                 reset,
  input  wire icache_pkg::addr_t    fetch_addr,
  output icache_pkg::block_t        fetch_data,
  output logic                      fetch_valid,
  output icache_pkg::bus_command_t  mem_command,
  output icache_pkg::addr_t         mem_addr,
  input  wire icache_pkg::mem_tag_t mem_response,
  input  wire icache_pkg::block_t   mem_data,
  input  wire icache_pkg::mem_tag_t mem_tag
);

  logic                                         addr_changed;
  icache_pkg::addr_t                            demand_block;
  icache_pkg::addr_t [`ICACHE_NUM_PREFETCH-1:0] prefetch_blocks;
  icache_pkg::addr_t                            head_block;
  icache_pkg::addr_t                            send_block;
  icache_pkg::addr_t                            wait_block;
  logic                                         send_req;
  logic                                         accepted;
  icache_pkg::mem_tag_t                         accepted_tag;
  logic                                         fill_done;
  icache_pkg::mem_tag_t                         wait_tag;
  logic                                         fill_en;
  icache_pkg::addr_t                            fill_block_addr;
  icache_pkg::block_t                           fill_data;
  logic [2:0]                                   rd_hit;
  icache_pkg::block_t [2:0]                     rd_data;

  // port 0 serves the fetch stage
  assign fetch_data  = rd_data[0];
  assign fetch_valid = rd_hit[0];

  fetch_addr_gen addr_gen0 (
    .clock           (clock),
    .reset           (reset),
    .fetch_addr      (fetch_addr),
    .addr_changed    (addr_changed),
    .demand_block    (demand_block),
    .prefetch_blocks (prefetch_blocks)
  );

  // port 1 checks the queue head, port 2 the next entry to send
  cache_array array0 (
    .clock           (clock),
    .reset           (reset),
    .rd_block        ({send_block, head_block, demand_block}),
    .rd_hit          (rd_hit),
    .rd_data         (rd_data),
    .fill_en         (fill_en),
    .fill_block_addr (fill_block_addr),
    .fill_data       (fill_data)
  );

  miss_queue queue0 (
    .clock           (clock),
    .reset           (reset),
    .addr_changed    (addr_changed),
    .demand_block    (demand_block),
    .prefetch_blocks (prefetch_blocks),
    .rd_hit          (rd_hit),
    .head_block      (head_block),
    .send_block      (send_block),
    .wait_block      (wait_block),
    .send_req        (send_req),
    .accepted        (accepted),
    .accepted_tag    (accepted_tag),
    .fill_done       (fill_done),
    .wait_tag        (wait_tag)
  );

  mem_bus_port bus0 (
    .clock           (clock),
    .reset           (reset),
    .send_req        (send_req),
    .send_block      (send_block),
    .wait_block      (wait_block),
    .wait_tag        (wait_tag),
    .mem_response    (mem_response),
    .mem_data        (mem_data),
    .mem_tag         (mem_tag),
    .mem_command     (mem_command),
    .mem_addr        (mem_addr),
    .accepted        (accepted),
    .accepted_tag    (accepted_tag),
    .fill_done       (fill_done),
    .fill_en         (fill_en),
    .fill_block_addr (fill_block_addr),
    .fill_data       (fill_data)
  );

endmodule

`default_nettype wire

// ==== bench/tb_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
  output logic clock,
  output logic reset
);

  localparam int HALF_PERIOD  = 10;
  localparam int RESET_CYCLES = 8;

  // 20 ns period
  initial begin
    clock = 1'b0;
    forever #HALF_PERIOD clock = ~clock;
  end

  initial begin
    reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge clock);
    reset <= 1'b0;
  end

endmodule

`default_nettype wire

// ==== bench/icache_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "icache_consts.svh"

module icache_tb;

  localparam int NUM_PATTERNS = 20;
  localparam int WATCHDOG_NS  = NUM_PATTERNS * 60 * 20;

  logic                     clock;
  logic                     reset;
  icache_pkg::addr_t        fetch_addr;
  icache_pkg::block_t       fetch_data;
  logic                     fetch_valid;
  icache_pkg::bus_command_t mem_command;
  icache_pkg::addr_t        mem_addr;
  icache_pkg::mem_tag_t     mem_response;
  icache_pkg::block_t       mem_data;
  icache_pkg::mem_tag_t     mem_tag;

  // each row holds address, dwell and expected block
  logic [63:0] pattern_mem [3*NUM_PATTERNS];

  logic [31:0]          lfsr_state;
  logic [31:0]          drawn;
  icache_pkg::mem_tag_t next_tag;
  icache_pkg::mem_tag_t next_response;
  icache_pkg::mem_tag_t ret_tag;
  icache_pkg::block_t   ret_data;
  icache_pkg::addr_t    out_addr [$];
  icache_pkg::mem_tag_t out_tag [$];
  int                   out_due [$];
  icache_pkg::addr_t    returned [$];
  logic                 retry_pending;
  icache_pkg::addr_t    retry_addr;
  int                   cycle;
  int                   errors;
  int                   tests_failed;

  tb_clock_gen clk0 (
    .clock (clock),
    .reset (reset)
  );

  icache dut0 (
    .clock        (clock),
    .reset        (reset),
    .fetch_addr   (fetch_addr),
    .fetch_data   (fetch_data),
    .fetch_valid  (fetch_valid),
    .mem_command  (mem_command),
    .mem_addr     (mem_addr),
    .mem_response (mem_response),
    .mem_data     (mem_data),
    .mem_tag      (mem_tag)
  );

  //////////////////////////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////////////////////////

  // galois form with taps x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic draw_bits(input int n, output logic [31:0] bits);
    bits = '0;
    for (int i = 0; i < n; i++) begin
      bits = {bits[30:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  // memory contents of a block
  function automatic icache_pkg::block_t block_rule(input icache_pkg::addr_t a);
    return {a ^ 32'h5a5a_5a5a, ~a};
  endfunction

  function automatic icache_pkg::addr_t block_of(input icache_pkg::addr_t a);
    return {a[31:3], 3'b000};
  endfunction

  // demand or prefetch block of some pattern row
  function automatic logic allowed_addr(input icache_pkg::addr_t a);
    icache_pkg::addr_t base;
    logic              found;
    found = 1'b0;
    for (int p = 0; p < NUM_PATTERNS; p++) begin
      base = block_of(pattern_mem[3*p][31:0]);
      for (int k = 0; k <= `ICACHE_NUM_PREFETCH; k++) begin
        if (a == base + icache_pkg::addr_t'(8 * k)) begin
          found = 1'b1;
        end
      end
    end
    return found;
  endfunction

  function automatic logic was_returned(input icache_pkg::addr_t a);
    logic found;
    found = 1'b0;
    for (int i = 0; i < returned.size(); i++) begin
      if (returned[i] == a) begin
        found = 1'b1;
      end
    end
    return found;
  endfunction

  task automatic check_block(input icache_pkg::block_t actual,
                             input icache_pkg::block_t expected, input string what);
    if (actual !== expected) begin
      errors++;
      $display("FAILED at %0t: %s, got %h expected %h", $time, what, actual, expected);
    end
  endtask

  task automatic check_addr(input icache_pkg::addr_t actual,
                            input icache_pkg::addr_t expected, input string what);
    if (actual !== expected) begin
      errors++;
      $display("FAILED at %0t: %s, got %h expected %h", $time, what, actual, expected);
    end
  endtask

  task automatic check_valid(input logic actual, input logic expected, input string what);
    if (actual !== expected) begin
      errors++;
      $display("FAILED at %0t: %s, got %b expected %b", $time, what, actual, expected);
    end
  endtask

  task automatic check_command(input icache_pkg::bus_command_t actual,
                               input icache_pkg::bus_command_t expected, input string what);
    if (actual !== expected) begin
      errors++;
      $display("FAILED at %0t: %s, got %h expected %h", $time, what, actual, expected);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // memory model
  //////////////////////////////////////////////////////////////////////

  task automatic observe_bus();
    if (!allowed_addr(mem_addr)) begin
      errors++;
      $display("FAILED at %0t: load of %h, a block no pattern asks for", $time, mem_addr);
    end
    if (retry_pending) begin
      check_addr(mem_addr, retry_addr, "address after a refusal");
    end
    if (mem_response == '0) begin
      retry_pending = 1'b1;
      retry_addr    = mem_addr;
    end else begin
      retry_pending = 1'b0;
      for (int i = 0; i < out_addr.size(); i++) begin
        if (out_addr[i] == mem_addr) begin
          errors++;
          $display("FAILED at %0t: %h accepted again before it returned", $time, mem_addr);
        end
      end
      // 6 to 13 cycles to return
      draw_bits(3, drawn);
      out_addr.push_back(mem_addr);
      out_tag.push_back(mem_response);
      out_due.push_back(cycle + 6 + int'(drawn[2:0]));
      next_tag = (next_tag == 4'hf) ? 4'h1 : next_tag + 4'h1;
    end
  endtask

  task automatic plan_return();
    ret_tag  = '0;
    ret_data = '0;
    if ((out_addr.size() > 0) && (cycle >= out_due[0])) begin
      ret_tag  = out_tag[0];
      ret_data = block_rule(out_addr[0]);
      returned.push_back(out_addr[0]);
      void'(out_addr.pop_front());
      void'(out_tag.pop_front());
      void'(out_due.pop_front());
    end
  endtask

  // decide at the falling edge, drive at the rising edge
  always @(negedge clock) begin
    if (reset) begin
      ret_tag       = '0;
      ret_data      = '0;
      next_response = '0;
      check_command(mem_command, icache_pkg::BUS_NONE, "command during reset");
      check_addr(mem_addr, '0, "address during reset");
      check_valid(fetch_valid, 1'b0, "fetch_valid during reset");
    end else begin
      cycle++;
      if (mem_command == icache_pkg::BUS_LOAD) begin
        observe_bus();
      end else begin
        check_command(mem_command, icache_pkg::BUS_NONE, "idle bus command");
      end
      plan_return();
      draw_bits(1, drawn);
      next_response = drawn[0] ? '0 : next_tag;
    end
  end

  always @(posedge clock) begin
    mem_response <= next_response;
    mem_tag      <= ret_tag;
    mem_data     <= ret_data;
  end

  //////////////////////////////////////////////////////////////////////
  // fetch side
  //////////////////////////////////////////////////////////////////////

  task automatic run_pattern(input int p);
    icache_pkg::addr_t  addr;
    icache_pkg::addr_t  blk;
    icache_pkg::block_t expected;
    int                 dwell;
    int                 errors_before;
    logic               seen;
    addr          = pattern_mem[3*p][31:0];
    blk           = block_of(addr);
    dwell         = int'(pattern_mem[3*p+1][31:0]);
    expected      = pattern_mem[3*p+2];
    errors_before = errors;
    seen          = 1'b0;
    for (int n = 0; n < dwell; n++) begin
      @(posedge clock);
      fetch_addr <= addr;
      @(negedge clock);
      // a dwell of one means a hit is due at once
      if ((n == 0) && (dwell == 1)) begin
        check_valid(fetch_valid, 1'b1, "hit in the first cycle");
      end
      if (fetch_valid) begin
        if (!was_returned(blk)) begin
          check_valid(fetch_valid, 1'b0, "fetch_valid before memory returned the block");
        end
        check_block(fetch_data, expected, "fetch data");
        seen = 1'b1;
      end
    end
    if (!seen && (dwell > 1)) begin
      errors++;
      $display("test %0d: fetch_valid never rose within %0d cycles", p, dwell);
    end
    if (errors == errors_before) begin
      $display("test %0d addr %h: passed", p, addr);
    end else begin
      tests_failed++;
      $display("test %0d addr %h: failed with %0d errors", p, addr, errors - errors_before);
    end
  endtask

  initial begin
    $readmemh("bench/icache_patterns.txt", pattern_mem);
    lfsr_state    = 32'hd9d3673b;
    next_tag      = 4'h1;
    next_response = '0;
    ret_tag       = '0;
    ret_data      = '0;
    retry_pending = 1'b0;
    retry_addr    = '0;
    cycle         = 0;
    errors        = 0;
    tests_failed  = 0;
    fetch_addr    = pattern_mem[0][31:0];
    mem_response  = '0;
    mem_tag       = '0;
    mem_data      = '0;
    @(negedge reset);
    for (int p = 0; p < NUM_PATTERNS; p++) begin
      run_pattern(p);
    end
    $display("tests %0d, failed %0d, errors %0d", NUM_PATTERNS, tests_failed, errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("timeout: the patterns did not finish within %0d ns", WATCHDOG_NS);
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== bench/icache_patterns.txt ====
// fetch address, dwell cycles (hex, 1 means a hit is due at once), expected block
// expected block upper word is block address ^ 5a5a5a5a, lower word its inverse
00001000 0000003c 5a5a4a5affffefff
00001008 00000001 5a5a4a52ffffeff7
00001010 00000001 5a5a4a4affffefef
00001004 00000001 5a5a4a5affffefff
00002000 00000030 5a5a7a5affffdfff
00001000 00000001 5a5a4a5affffefff
00003010 0000003c 5a5a6a4affffcfef
00003018 00000001 5a5a6a42ffffcfe7
00003020 00000001 5a5a6a7affffcfdf
00004028 00000030 5a5a1a72ffffbfd7
00005028 00000030 5a5a0a72ffffafd7
00006028 00000030 5a5a3a72ffff9fd7
00007028 00000030 5a5a2a72ffff8fd7
00008028 00000030 5a5ada72ffff7fd7
00004028 00000030 5a5a1a72ffffbfd7
0000a0f4 0000003c 5a5afaaaffff5f0f
0000a0fc 00000001 5a5afaa2ffff5f07
0000a100 00000001 5a5afb5affff5eff
00002004 00000001 5a5a7a5affffdfff
0000a0f0 00000001 5a5afaaaffff5f0f

// ==== compile.f ====
+incdir+verilog
verilog/icache_pkg.sv
verilog/fetch_addr_gen.sv
verilog/cache_array.sv
verilog/miss_queue.sv
verilog/mem_bus_port.sv
verilog/icache.sv
bench/tb_clock_gen.sv
bench/icache_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall
TOP       := icache_tb
FILELIST  := compile.f
OBJ_DIR   := obj_dir
PASS_MSG  := ALL TESTS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
